// ==== logic/riscvPkg.sv ====
package riscvPkg;

	localparam int XLEN   = 32; // Data word width
	localparam int ADDR_W = 12; // Byte address width of the shared memory

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASSB // Operand B straight through, used by LUI
	} aluOpT;

	// RV32I major opcodes
	localparam logic [6:0] OP     = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] LUI    = 7'b0110111;
	localparam logic [6:0] AUIPC  = 7'b0010111;
	localparam logic [6:0] JAL    = 7'b1101111;
	localparam logic [6:0] JALR   = 7'b1100111;
	localparam logic [6:0] BRANCH = 7'b1100011;
	localparam logic [6:0] LOAD   = 7'b0000011;
	localparam logic [6:0] STORE  = 7'b0100011;
	localparam logic [6:0] SYSTEM = 7'b1110011;

	localparam logic [ADDR_W-1:0] RESET_PC    = '0;
	localparam logic [XLEN-1:0]   EBREAK_WORD = 32'h0010_0073;

	// Requester ids at the memory arbiter
	localparam logic ARB_FETCH = 1'b0;
	localparam logic ARB_DATA  = 1'b1;

endpackage

// ==== logic/aluUnit.sv ====
`timescale 1ns/10ps

module aluUnit import riscvPkg::*; (
	input  aluOpT           aluOp,
	input  logic [XLEN-1:0] aluA,
	input  logic [XLEN-1:0] aluB,
	output logic [XLEN-1:0] aluY
);

	logic [4:0] shamt;

	assign shamt = aluB[4:0]; // RV32I shift amount

	always_comb begin
		case (aluOp)
			ALU_ADD:   aluY = aluA + aluB;
			ALU_SUB:   aluY = aluA - aluB;
			ALU_AND:   aluY = aluA & aluB;
			ALU_OR:    aluY = aluA | aluB;
			ALU_XOR:   aluY = aluA ^ aluB;
			ALU_SLT:   aluY = {{(XLEN-1){1'b0}}, $signed(aluA) < $signed(aluB)};
			ALU_SLTU:  aluY = {{(XLEN-1){1'b0}}, aluA < aluB};
			ALU_SLL:   aluY = aluA << shamt;
			ALU_SRL:   aluY = aluA >> shamt;
			ALU_SRA:   aluY = $signed(aluA) >>> shamt;
			ALU_PASSB: aluY = aluB;
			default:   aluY = '0;
		endcase
	end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/10ps

module regFile import riscvPkg::*; (
	input  logic            CLK,
	input  logic [4:0]      ra1,
	input  logic [4:0]      ra2,
	output logic [XLEN-1:0] rd1,
	output logic [XLEN-1:0] rd2,
	input  logic            we,
	input  logic [4:0]      wa,
	input  logic [XLEN-1:0] wd
);

	logic [XLEN-1:0] regs [1:31]; // No storage behind x0

	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

	always_ff @(posedge CLK) begin
		if (we && wa != 5'd0)
			regs[wa] <= wd;
	end

endmodule

// ==== logic/memArbiter.sv ====
`timescale 1ns/10ps

module memArbiter import riscvPkg::*; (
	input  logic              CLK,
	input  logic              RSTn,
	input  logic              fetchReq,
	input  logic [ADDR_W-1:0] fetchAddr,
	output logic              fetchAck,
	input  logic              dataReq,
	input  logic [ADDR_W-1:0] dataAddr,
	input  logic              dataWe,
	input  logic [XLEN-1:0]   dataWdata,
	output logic              dataAck,
	output logic [XLEN-1:0]   rdata,
	output logic              memReq,
	input  logic              memAck,
	output logic              memWe,
	output logic [ADDR_W-1:0] memAddr,
	output logic [XLEN-1:0]   memWdata,
	output logic [3:0]        memBe,
	input  logic [XLEN-1:0]   memRdata
);

	typedef enum logic [1:0] {arbIdle, arbMem, arbAck, arbDone} arbStateT;
	arbStateT state;
	logic     owner;    // Granted peer
	logic     peerAck;  // Ack toward the owner
	logic     ownerReq;

	assign ownerReq = (owner == ARB_DATA) ? dataReq : fetchReq;
	assign fetchAck = peerAck && (owner == ARB_FETCH);
	assign dataAck  = peerAck && (owner == ARB_DATA);
	assign memBe    = 4'b1111; // Word access only

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state   <= arbIdle;
			owner   <= ARB_FETCH;
			memReq  <= 1'b0;
			memWe   <= 1'b0;
			peerAck <= 1'b0;
		end else begin
			case (state)
				arbIdle: if (dataReq || fetchReq) begin
					owner  <= dataReq ? ARB_DATA : ARB_FETCH; // Data wins a tie
					memReq <= 1'b1;
					memWe  <= dataReq && dataWe;
					state  <= arbMem;
				end
				arbMem: if (memAck) begin
					memReq  <= 1'b0;
					peerAck <= 1'b1;
					state   <= arbAck;
				end
				arbAck: if (!ownerReq) begin
					peerAck <= 1'b0;
					state   <= arbDone;
				end
				arbDone: if (!memAck) state <= arbIdle; // Both sides back to idle
				default: state <= arbIdle;
			endcase
		end
	end

	// Address and write data frozen from grant on
	always_ff @(posedge CLK) begin
		if (state == arbIdle) begin
			memAddr  <= dataReq ? dataAddr : fetchAddr;
			memWdata <= dataWdata;
		end
		if (state == arbMem && memAck)
			rdata <= memRdata;
	end

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/10ps

module fetchUnit import riscvPkg::*; (
	input  logic              CLK,
	input  logic              RSTn,
	input  logic              halt,
	output logic              fetchReq,
	output logic [ADDR_W-1:0] fetchAddr,
	input  logic              fetchAck,
	input  logic [XLEN-1:0]   rdata,
	output logic              instrReq,
	output logic [XLEN-1:0]   instr,
	output logic [ADDR_W-1:0] pc,
	input  logic              instrAck,
	input  logic [ADDR_W-1:0] pcNext
);

	typedef enum logic [1:0] {fsIdle, fsFetch, fsFetchDone, fsOffer} fetchStateT;
	fetchStateT state;

	assign fetchAddr = pc; // pc only moves on retirement

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state    <= fsIdle;
			fetchReq <= 1'b0;
			instrReq <= 1'b0;
			pc       <= RESET_PC;
		end else begin
			case (state)
				fsIdle: if (!halt && !instrAck) begin // Previous hand-off fully closed
					fetchReq <= 1'b1;
					state    <= fsFetch;
				end
				fsFetch: if (fetchAck) begin
					fetchReq <= 1'b0;
					state    <= fsFetchDone;
				end
				fsFetchDone: if (!fetchAck) begin
					instrReq <= 1'b1;
					state    <= fsOffer;
				end
				fsOffer: if (instrAck) begin // Retired
					pc       <= pcNext;
					instrReq <= 1'b0;
					state    <= fsIdle;
				end
				default: state <= fsIdle;
			endcase
		end
	end

	// Instruction word held for execute
	always_ff @(posedge CLK) begin
		if (state == fsFetch && fetchAck)
			instr <= rdata;
	end

endmodule

// ==== logic/execUnit.sv ====
`timescale 1ns/10ps

module execUnit import riscvPkg::*; (
	input  logic              CLK,
	input  logic              RSTn,
	input  logic              instrReq,
	input  logic [XLEN-1:0]   instr,
	input  logic [ADDR_W-1:0] pc,
	output logic              instrAck,
	output logic [ADDR_W-1:0] pcNext,
	output logic              dataReq,
	output logic [ADDR_W-1:0] dataAddr,
	output logic              dataWe,
	output logic [XLEN-1:0]   dataWdata,
	input  logic              dataAck,
	input  logic [XLEN-1:0]   rdata,
	output logic [4:0]        rfRa1,
	output logic [4:0]        rfRa2,
	output logic [4:0]        rfWa,
	input  logic [XLEN-1:0]   rfRd1,
	input  logic [XLEN-1:0]   rfRd2,
	output logic              rfWe,
	output logic [XLEN-1:0]   rfWd,
	output aluOpT             aluOp,
	output logic [XLEN-1:0]   aluA,
	output logic [XLEN-1:0]   aluB,
	input  logic [XLEN-1:0]   aluY,
	output logic              halt,
	output logic [XLEN-1:0]   numInst
);

	typedef enum logic [2:0] {stIdle, stExec, stMem, stMemDone, stAck} execStateT;
	execStateT state;

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [XLEN-1:0]   immI, immS, immB, immU, immJ;
	logic [ADDR_W-1:0] pc4, nextPc;
	logic [XLEN-1:0]   pcExt, linkExt;
	logic [XLEN-1:0]   loadData;
	logic              isLoad, isMem, writesRd, isEbreak, taken;
	aluOpT             funcOp;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rfRa1  = instr[19:15];
	assign rfRa2  = instr[24:20];
	assign rfWa   = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign isLoad   = (opcode == LOAD);
	assign isMem    = isLoad || (opcode == STORE);
	assign writesRd = (opcode == OP) || (opcode == OP_IMM) || (opcode == LUI) ||
	                  (opcode == AUIPC) || (opcode == JAL) || (opcode == JALR);
	assign isEbreak = (opcode == SYSTEM) && (instr == EBREAK_WORD);

	assign pc4     = pc + ADDR_W'(4);
	assign pcExt   = {{(XLEN-ADDR_W){1'b0}}, pc};
	assign linkExt = {{(XLEN-ADDR_W){1'b0}}, pc4};

	// Register and immediate ALU forms share funct3 decoding
	always_comb begin
		case (funct3)
			3'b000: funcOp = (opcode == OP && instr[30]) ? ALU_SUB : ALU_ADD;
			3'b001: funcOp = ALU_SLL;
			3'b010: funcOp = ALU_SLT;
			3'b011: funcOp = ALU_SLTU;
			3'b100: funcOp = ALU_XOR;
			3'b101: funcOp = instr[30] ? ALU_SRA : ALU_SRL;
			3'b110: funcOp = ALU_OR;
			default: funcOp = ALU_AND;
		endcase
	end

	always_comb begin
		aluOp = ALU_ADD; // rs1 + immI covers LOAD and JALR
		aluA  = rfRd1;
		aluB  = immI;
		case (opcode)
			OP: begin
				aluOp = funcOp;
				aluB  = rfRd2;
			end
			OP_IMM: aluOp = funcOp;
			LUI: begin
				aluOp = ALU_PASSB;
				aluB  = immU;
			end
			AUIPC: begin
				aluA = pcExt;
				aluB = immU;
			end
			BRANCH: begin // Zero test for BEQ/BNE, signed compare for BLT/BGE
				aluOp = funct3[2] ? ALU_SLT : ALU_SUB;
				aluB  = rfRd2;
			end
			STORE: aluB = immS;
			default: ;
		endcase
	end

	assign taken = funct3[2] ? (aluY[0] ^ funct3[0]) : ((aluY == '0) ^ funct3[0]);

	always_comb begin
		case (opcode)
			JAL:     nextPc = pc + immJ[ADDR_W-1:0];
			JALR:    nextPc = {aluY[ADDR_W-1:1], 1'b0};
			BRANCH:  nextPc = taken ? pc + immB[ADDR_W-1:0] : pc4;
			default: nextPc = pc4;
		endcase
	end

	assign dataAddr  = aluY[ADDR_W-1:0];
	assign dataWe    = (opcode == STORE);
	assign dataWdata = rfRd2;

	// One write per instruction, loads once the data handshake has closed
	assign rfWe = (state == stExec && writesRd) || (state == stMemDone && !dataAck && isLoad);
	assign rfWd = (state == stMemDone) ? loadData :
	              (opcode == JAL || opcode == JALR) ? linkExt : aluY;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state    <= stIdle;
			instrAck <= 1'b0;
			pcNext   <= RESET_PC;
			dataReq  <= 1'b0;
			halt     <= 1'b0;
			numInst  <= '0;
		end else begin
			case (state)
				stIdle: if (instrReq) state <= stExec;
				stExec: begin
					pcNext <= nextPc; // Registered before rd can change rs1
					if (isMem) begin
						dataReq <= 1'b1;
						state   <= stMem;
					end else begin
						instrAck <= 1'b1;
						numInst  <= numInst + 1'b1;
						if (isEbreak)
							halt <= 1'b1;
						state <= stAck;
					end
				end
				stMem: if (dataAck) begin
					dataReq <= 1'b0;
					state   <= stMemDone;
				end
				stMemDone: if (!dataAck) begin
					instrAck <= 1'b1;
					numInst  <= numInst + 1'b1;
					state    <= stAck;
				end
				stAck: if (!instrReq) begin
					instrAck <= 1'b0;
					state    <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == stMem && dataAck)
			loadData <= rdata;
	end

endmodule

// ==== logic/riscvTop.sv ====
`timescale 1ns/10ps

module riscvTop import riscvPkg::*; (
	input  logic              CLK,
	input  logic              RSTn,
	output logic              memReq,
	input  logic              memAck,
	output logic              memWe,
	output logic [ADDR_W-1:0] memAddr,
	output logic [XLEN-1:0]   memWdata,
	output logic [3:0]        memBe,
	input  logic [XLEN-1:0]   memRdata,
	output logic              halt,
	output logic [XLEN-1:0]   numInst,
	output logic [XLEN-1:0]   outputPort // Register write value
);

	logic              fetchReq, fetchAck;
	logic [ADDR_W-1:0] fetchAddr;
	logic              dataReq, dataAck, dataWe;
	logic [ADDR_W-1:0] dataAddr;
	logic [XLEN-1:0]   dataWdata;
	logic [XLEN-1:0]   arbRdata; // Word returned to either peer
	logic              instrReq, instrAck;
	logic [XLEN-1:0]   instr;
	logic [ADDR_W-1:0] pc, pcNext;
	logic [4:0]        rfRa1, rfRa2, rfWa;
	logic [XLEN-1:0]   rfRd1, rfRd2;
	logic              rfWe;
	aluOpT             aluOp;
	logic [XLEN-1:0]   aluA, aluB, aluY;

	fetchUnit uFetch (
		.CLK(CLK), .RSTn(RSTn), .halt(halt),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchAck(fetchAck), .rdata(arbRdata),
		.instrReq(instrReq), .instr(instr), .pc(pc), .instrAck(instrAck), .pcNext(pcNext)
	);

	execUnit uExec (
		.CLK(CLK), .RSTn(RSTn),
		.instrReq(instrReq), .instr(instr), .pc(pc), .instrAck(instrAck), .pcNext(pcNext),
		.dataReq(dataReq), .dataAddr(dataAddr), .dataWe(dataWe), .dataWdata(dataWdata),
		.dataAck(dataAck), .rdata(arbRdata),
		.rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa), .rfRd1(rfRd1), .rfRd2(rfRd2),
		.rfWe(rfWe), .rfWd(outputPort),
		.aluOp(aluOp), .aluA(aluA), .aluB(aluB), .aluY(aluY),
		.halt(halt), .numInst(numInst)
	);

	regFile uRegFile (
		.CLK(CLK), .ra1(rfRa1), .ra2(rfRa2), .rd1(rfRd1), .rd2(rfRd2),
		.we(rfWe), .wa(rfWa), .wd(outputPort)
	);

	aluUnit uAlu (.aluOp(aluOp), .aluA(aluA), .aluB(aluB), .aluY(aluY));

	memArbiter uArbiter (
		.CLK(CLK), .RSTn(RSTn),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchAck(fetchAck),
		.dataReq(dataReq), .dataAddr(dataAddr), .dataWe(dataWe), .dataWdata(dataWdata),
		.dataAck(dataAck), .rdata(arbRdata),
		.memReq(memReq), .memAck(memAck), .memWe(memWe), .memAddr(memAddr),
		.memWdata(memWdata), .memBe(memBe), .memRdata(memRdata)
	);

endmodule

// ==== tb/riscvTop_assert.sv ====
`timescale 1ns/10ps

module riscvTop_assert import riscvPkg::*; (
	input logic              CLK,
	input logic              RSTn,
	input logic              memReq,
	input logic              memAck,
	input logic              memWe,
	input logic [ADDR_W-1:0] memAddr,
	input logic              halt
);

	int assertFails = 0;

	reqHeld: assert property (@(posedge CLK) disable iff (RSTn)
		memReq && !memAck |=> memReq)
		else begin
			$error("memReq dropped before memAck");
			assertFails++;
		end

	// Payload frozen for the whole request
	payloadStable: assert property (@(posedge CLK) disable iff (RSTn)
		memReq |=> !memReq || ($stable(memAddr) && $stable(memWe)))
		else begin
			$error("memAddr or memWe changed during a request");
			assertFails++;
		end

	noReqHalted: assert property (@(posedge CLK) disable iff (RSTn) halt |-> !$rose(memReq))
		else begin
			$error("memReq rose while halted");
			assertFails++;
		end

	idleAfterReset: assert property (@(posedge CLK) RSTn |=> !memReq)
		else begin
			$error("memReq high right after reset");
			assertFails++;
		end

endmodule

bind riscvTop riscvTop_assert uAssert (
	.CLK(CLK), .RSTn(RSTn), .memReq(memReq), .memAck(memAck),
	.memWe(memWe), .memAddr(memAddr), .halt(halt)
);

// ==== tb/riscvTop_tb.sv ====
`timescale 1ns/10ps

module riscvTop_tb import riscvPkg::*; ();

	localparam int TESTS      = 5;
	localparam int TEST_LIMIT = 400; // Cycles allowed per test
	localparam int DATA_BASE  = 256; // Word index of byte address 0x400

	logic              CLK;
	logic              RSTn;
	logic              memReq, memAck, memWe, halt;
	logic [ADDR_W-1:0] memAddr;
	logic [XLEN-1:0]   memWdata, memRdata, numInst, outputPort;
	logic [3:0]        memBe;

	logic [XLEN-1:0] mem [0:1023];
	int              progLen;
	int              cycles = 0;
	logic [XLEN-1:0] writeLog [$]; // outputPort of each retired instruction
	logic [XLEN-1:0] lastPort, lastCount;

	riscvTop dut (
		.CLK(CLK), .RSTn(RSTn), .memReq(memReq), .memAck(memAck), .memWe(memWe),
		.memAddr(memAddr), .memWdata(memWdata), .memBe(memBe), .memRdata(memRdata),
		.halt(halt), .numInst(numInst), .outputPort(outputPort)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TESTS * TEST_LIMIT) begin
			$display("Timeout: the core did not finish its programs within %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Simulation stopped on timeout");
		end
	end

	// Write value seen in the cycle before numInst steps
	always @(posedge CLK) begin
		#1;
		if (!RSTn && numInst != lastCount)
			writeLog.push_back(lastPort);
		lastPort  = outputPort;
		lastCount = numInst;
	end

	// Word memory behind the external handshake
	initial begin
		int delay;
		void'($urandom(19266));
		memAck   = 1'b0;
		memRdata = '0;
		forever begin
			@(posedge CLK);
			#1;
			if (memReq && !RSTn) begin
				checkValue(memBe, 4'hF, "memBe on request");
				delay = $urandom % 4; // 0 to 3 cycles
				if (delay > 0) begin
					repeat (delay) @(posedge CLK);
					#1;
				end
				if (memWe)
					mem[memAddr[ADDR_W-1:2]] = memWdata;
				else
					memRdata = mem[memAddr[ADDR_W-1:2]];
				memAck = 1'b1;
				do begin
					@(posedge CLK);
					#1;
				end while (memReq); // Ack drops only after req
				memAck = 1'b0;
			end
		end
	end

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] iType(input logic [6:0] opc, input logic [4:0] rd,
		input logic [2:0] f3, input logic [4:0] rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sType(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [31:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE}; // SW only
	endfunction

	function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic logic [31:0] uType(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jType(input logic [4:0] rd, input logic [31:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	function automatic logic [31:0] fillWord(input int idx);
		return {16'hA5A5, idx[15:0]};
	endfunction

	task automatic clearMemory();
		for (int i = 0; i < 1024; i++)
			mem[i] = fillWord(i);
		progLen = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		mem[progLen] = word;
		progLen++;
	endtask

	task automatic pulseReset();
		@(posedge CLK);
		#1 RSTn = 1'b1;
		writeLog.delete();
		repeat (2) @(posedge CLK);
		#1 RSTn = 1'b0;
	endtask

	task automatic waitForHalt();
		while (!halt) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic aluOps();
		logic signed [31:0] a, b;
		logic [31:0]        exp [1:12];
		a = -7;
		b = 12;
		exp[1] = a;
		exp[2] = b;
		exp[3] = a + b;
		exp[4] = a - b;
		exp[5] = a ^ b;
		exp[6] = a | b;
		exp[7] = a & b;
		exp[8] = (a < b) ? 1 : 0;
		exp[9] = ($unsigned(a) < $unsigned(b)) ? 1 : 0;
		exp[10] = a << 3;
		exp[11] = $unsigned(a) >> 4;
		exp[12] = a >>> 4;
		clearMemory();
		emit(iType(OP_IMM, 31, 3'b000, 0, 32'h400)); // Data base
		emit(iType(OP_IMM, 1, 3'b000, 0, a));
		emit(iType(OP_IMM, 2, 3'b000, 0, b));
		emit(rType(7'h00, 3'b000, 3, 1, 2));
		emit(rType(7'h20, 3'b000, 4, 1, 2));
		emit(rType(7'h00, 3'b100, 5, 1, 2));
		emit(rType(7'h00, 3'b110, 6, 1, 2));
		emit(rType(7'h00, 3'b111, 7, 1, 2));
		emit(rType(7'h00, 3'b010, 8, 1, 2));
		emit(rType(7'h00, 3'b011, 9, 1, 2));
		emit(iType(OP_IMM, 10, 3'b001, 1, 3));
		emit(iType(OP_IMM, 11, 3'b101, 1, 4));
		emit(iType(OP_IMM, 12, 3'b101, 1, 32'h404)); // SRAI
		for (int r = 1; r <= 12; r++)
			emit(sType(r, 31, (r - 1) * 4));
		emit(EBREAK_WORD);
		pulseReset();
		waitForHalt();
		for (int r = 1; r <= 12; r++)
			checkValue(mem[DATA_BASE + r - 1], exp[r], $sformatf("ALU result x%0d", r));
		checkValue(writeLog[0], 32'h400, "write value of x31");
		for (int r = 1; r <= 12; r++)
			checkValue(writeLog[r], exp[r], $sformatf("write value of x%0d", r));
	endtask

	task automatic upperImmediates();
		clearMemory();
		emit(iType(OP_IMM, 31, 3'b000, 0, 32'h400));
		emit(uType(LUI, 1, 20'hABCDE));
		emit(uType(AUIPC, 2, 20'h00012)); // At byte address 8
		emit(sType(1, 31, 0));
		emit(sType(2, 31, 4));
		emit(EBREAK_WORD);
		pulseReset();
		waitForHalt();
		checkValue(mem[DATA_BASE], 32'hABCDE000, "LUI result");
		checkValue(mem[DATA_BASE + 1], 32'd8 + 32'h00012000, "AUIPC result");
	endtask

	task automatic controlFlow();
		clearMemory();
		emit(iType(OP_IMM, 31, 3'b000, 0, 32'h400));
		emit(iType(OP_IMM, 1, 3'b000, 0, 5));
		emit(iType(OP_IMM, 2, 3'b000, 0, 5));
		emit(iType(OP_IMM, 3, 3'b000, 0, -3));
		emit(bType(3'b000, 1, 2, 8)); // BEQ taken
		emit(sType(0, 31, 0));
		emit(bType(3'b001, 1, 2, 8)); // BNE not taken
		emit(iType(OP_IMM, 10, 3'b000, 0, 1));
		emit(bType(3'b100, 3, 1, 8)); // BLT taken
		emit(sType(0, 31, 4));
		emit(bType(3'b101, 3, 1, 8)); // BGE not taken
		emit(iType(OP_IMM, 10, 3'b000, 10, 2));
		emit(bType(3'b101, 1, 3, 8)); // BGE taken
		emit(sType(0, 31, 8));
		emit(bType(3'b000, 1, 3, 8)); // BEQ not taken
		emit(iType(OP_IMM, 10, 3'b000, 10, 4));
		emit(bType(3'b100, 1, 3, 8)); // BLT not taken
		emit(iType(OP_IMM, 10, 3'b000, 10, 8));
		emit(jType(5, 8));            // JAL at byte 72
		emit(sType(0, 31, 12));
		emit(iType(OP_IMM, 6, 3'b000, 0, 91));
		emit(iType(JALR, 7, 3'b000, 6, 2)); // Target 93 rounds down to 92
		emit(sType(0, 31, 16));
		emit(sType(10, 31, 20));
		emit(sType(5, 31, 24));
		emit(sType(7, 31, 28));
		emit(EBREAK_WORD);
		pulseReset();
		waitForHalt();
		for (int i = 0; i < 5; i++)
			checkValue(mem[DATA_BASE + i], fillWord(DATA_BASE + i), $sformatf("marker %0d", i));
		checkValue(mem[DATA_BASE + 5], 15, "fall-through sum");
		checkValue(mem[DATA_BASE + 6], 76, "JAL link");
		checkValue(mem[DATA_BASE + 7], 88, "JALR link");
		checkValue(numInst, 22, "retired count"); // 27 words, 5 skipped
	endtask

	task automatic loadStore();
		clearMemory();
		emit(iType(OP_IMM, 31, 3'b000, 0, 32'h400));
		emit(iType(OP_IMM, 1, 3'b000, 0, 100));
		emit(iType(OP_IMM, 2, 3'b000, 0, -200));
		emit(uType(LUI, 3, 20'h12345));
		emit(sType(1, 31, 0));
		emit(sType(2, 31, 4));
		emit(sType(3, 31, 8));
		emit(iType(LOAD, 4, 3'b010, 31, 0));
		emit(iType(LOAD, 5, 3'b010, 31, 4));
		emit(iType(LOAD, 6, 3'b010, 31, 8));
		emit(rType(7'h00, 3'b000, 7, 4, 5));
		emit(rType(7'h20, 3'b000, 8, 6, 4));
		emit(sType(7, 31, 12));
		emit(sType(8, 31, 16));
		emit(EBREAK_WORD);
		pulseReset();
		waitForHalt();
		checkValue(mem[DATA_BASE], 100, "stored word 0");
		checkValue(mem[DATA_BASE + 1], -200, "stored word 1");
		checkValue(mem[DATA_BASE + 2], 32'h12345000, "stored word 2");
		checkValue(mem[DATA_BASE + 3], 100 - 200, "sum of loads");
		checkValue(mem[DATA_BASE + 4], 32'h12345000 - 100, "difference of loads");
		checkValue(writeLog[7], 100, "loaded x4");
		checkValue(writeLog[8], -200, "loaded x5");
		checkValue(writeLog[9], 32'h12345000, "loaded x6");
	endtask

	task automatic haltAndReset();
		clearMemory();
		emit(iType(OP_IMM, 1, 3'b000, 0, 42));
		emit(sType(1, 0, 1024));
		emit(EBREAK_WORD);
		pulseReset();
		waitForHalt();
		checkValue(mem[DATA_BASE], 42, "first run store");
		checkValue(numInst, 3, "retired count at first halt");
		repeat (50) begin
			@(posedge CLK);
			#1;
			checkValue(halt, 1'b1, "halt while stopped");
			checkValue(memReq, 1'b0, "memReq while halted");
		end
		mem[DATA_BASE] = '0;
		pulseReset();
		checkValue(halt, 1'b0, "halt after reset");
		checkValue(numInst, 0, "numInst after reset");
		repeat (2) begin
			@(posedge CLK);
			#1;
		end
		checkValue(memReq, 1'b1, "first memReq after reset");
		checkValue(memAddr, RESET_PC, "first fetch address");
		waitForHalt();
		checkValue(mem[DATA_BASE], 42, "second run store");
		checkValue(numInst, 3, "retired count at second halt");
	endtask

	initial begin
		RSTn = 1'b1; // Held in reset until the first test
		aluOps();
		upperImmediates();
		controlFlow();
		loadStore();
		haltAndReset();
		if (dut.uAssert.assertFails != 0) begin
			$display("Bound assertions failed %0d times", dut.uAssert.assertFails);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Assertion failures");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== riscvTop.f ====
logic/riscvPkg.sv
logic/aluUnit.sv
logic/regFile.sv
logic/memArbiter.sv
logic/fetchUnit.sv
logic/execUnit.sv
logic/riscvTop.sv
tb/riscvTop_assert.sv
tb/riscvTop_tb.sv

// ==== Bender.yml ====
package:
  name: riscvtop

sources:
  - logic/riscvPkg.sv
  - logic/aluUnit.sv
  - logic/regFile.sv
  - logic/memArbiter.sv
  - logic/fetchUnit.sv
  - logic/execUnit.sv
  - logic/riscvTop.sv
  - target: test
    files:
      - tb/riscvTop_assert.sv
      - tb/riscvTop_tb.sv
